//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - verilog/cache_cfg_pkg.sv
      - verilog/cache_bus_pkg.sv
      - verilog/set_array.sv
      - verilog/line_data_array.sv
      - verilog/lru_victim_select.sv
      - verilog/writeback_buffer.sv
      - verilog/cache_ctrl.sv
      - verilog/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_tb.sv

//--- sim/dcache_input.txt
// op(0 read, 1 write) addr wdata wstrb expected_rdata refills writebacks, all hex
// set 0 fills four ways, fifth line evicts by oldest stamp; set 1 at the end
0 00000004 00000000 0 0000000d 1 0
0 00000004 00000000 0 0000000d 0 0
0 0000001c 00000000 0 00000055 0 0
1 00000008 aabbccdd 5 00000000 0 0
0 00000008 00000000 0 00bb00dd 0 0
0 00000100 00000000 0 00000301 1 0
0 00000204 00000000 0 0000060d 1 0
0 00000308 00000000 0 00000919 1 0
0 00000400 00000000 0 00000c01 1 1
0 00000008 00000000 0 00bb00dd 1 0
1 00000104 11223344 f 00000000 1 0
1 00000110 55667788 3 00000000 0 0
0 00000104 00000000 0 11223344 0 0
0 00000300 00000000 0 00000901 0 0
0 00000500 00000000 0 00000f01 1 0
0 00000600 00000000 0 00001201 1 0
0 00000700 00000000 0 00001501 1 1
0 00000110 00000000 0 00007788 1 0
0 00000104 00000000 0 11223344 0 0
1 00000020 deadbeef 8 00000000 1 0
0 00000020 00000000 0 de000061 0 0

//--- sim/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb import cache_cfg_pkg::*, cache_bus_pkg::*; ();

    localparam int CLK_PERIOD     = 4;
    localparam int MEM_WORDS      = 1024;   // 4 KB model, byte addresses 0 to 'hfff
    localparam int FIELDS         = 7;      // words per access in the input file
    localparam int MAX_ACC        = 64;
    localparam int CYCLES_PER_ACC = 400;

    logic       clk, rst;
    logic       req_valid, req_ready, rsp_valid, rsp_ready;
    cpu_req_t   req;
    word_t      rsp_data;
    logic       rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_ready;
    line_addr_t rd_req_addr;
    mem_beat_t  rd_rsp;
    logic       wr_req_valid, wr_req_ready, wr_data_valid, wr_data_ready;
    line_addr_t wr_req_addr;
    mem_beat_t  wr_data;

    integer      seed = 32'h59c02641;
    word_t       mem [MEM_WORDS];
    logic [31:0] stim [MAX_ACC*FIELDS];
    int          n_acc = 0;
    int          cur_access = -1;   // shown in error lines
    int          rd_reqs, rd_beats, wr_reqs, wr_beats;
    line_addr_t  rd_line, wr_line;

    dcache_top dut0 (
        .clk, .rst,
        .req_valid, .req, .req_ready, .rsp_valid, .rsp_data, .rsp_ready,
        .rd_req_valid, .rd_req_addr, .rd_req_ready, .rd_rsp_valid, .rd_rsp, .rd_rsp_ready,
        .wr_req_valid, .wr_req_addr, .wr_req_ready, .wr_data_valid, .wr_data, .wr_data_ready
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t access %0d: %s, got %h expected %h", $time, cur_access, what,
                     got, exp);
            stop_with_failure();
        end
    endtask

    // ----------------------------------------------------------------------
    // memory model, refill side
    // ----------------------------------------------------------------------
    initial begin : refill_model
        logic [29:0] widx;
        rd_req_ready = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp       = '0;
        rd_reqs      = 0;
        rd_beats     = 0;
        forever begin
            @(posedge clk);
            if (rd_req_valid && rd_req_ready) begin
                rd_line = rd_req_addr;
                rd_reqs++;
                rd_req_ready <= 1'b0;
                for (int b = 0; b < LINE_WORDS; b++) begin
                    while (($random(seed) & 3) == 0) begin   // random gap before a beat
                        rd_rsp_valid <= 1'b0;
                        @(posedge clk);
                    end
                    widx = {rd_line, 3'(b)};
                    check_equal(32'(widx < MEM_WORDS), 1, "refill address inside memory model");
                    rd_rsp_valid <= 1'b1;
                    rd_rsp       <= '{data: mem[widx], last: (b == LINE_WORDS - 1)};
                    @(posedge clk);
                    while (!rd_rsp_ready) @(posedge clk);   // hold beat until taken
                    rd_beats++;
                end
                rd_rsp_valid <= 1'b0;
            end else begin
                rd_req_ready <= ($random(seed) & 3) != 0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // memory model, write-back side
    // ----------------------------------------------------------------------
    initial begin : writeback_model
        logic [29:0] widx;
        int          beat;
        wr_req_ready  = 1'b0;
        wr_data_ready = 1'b0;
        wr_reqs       = 0;
        wr_beats      = 0;
        beat          = LINE_WORDS;   // no burst open
        forever begin
            @(posedge clk);
            if (wr_data_valid && wr_data_ready) begin
                check_equal(32'(beat < LINE_WORDS), 1, "write beat outside a burst");
                widx = {wr_line, 3'(beat)};
                check_equal(32'(widx < MEM_WORDS), 1, "write-back address inside memory model");
                check_equal(32'(wr_data.last), 32'(beat == LINE_WORDS - 1), "write beat last flag");
                mem[widx] = wr_data.data;
                beat++;
                wr_beats++;
            end
            if (wr_req_valid && wr_req_ready) begin
                check_equal(beat, LINE_WORDS, "write request before previous burst ended");
                wr_line = wr_req_addr;
                wr_reqs++;
                beat    = 0;
            end
            wr_req_ready  <= ($random(seed) & 3) != 0;
            wr_data_ready <= ($random(seed) & 1) != 0;   // heavy back-pressure on data
        end
    end

    initial begin : rsp_stall
        rsp_ready = 1'b0;
        forever begin
            @(posedge clk);
            rsp_ready <= ($random(seed) & 3) != 0;
        end
    end

    // one access from the input file, start to finish
    task automatic run_access(input int i);
        logic [31:0] op, addr, wdata, wstrb, exp_data, exp_rd, exp_wr;
        cpu_req_t    r;
        int          edges;
        int          rd0, rb0, wr0, wb0;
        cur_access = i;
        op       = stim[i*FIELDS];
        addr     = stim[i*FIELDS+1];
        wdata    = stim[i*FIELDS+2];
        wstrb    = stim[i*FIELDS+3];
        exp_data = stim[i*FIELDS+4];
        exp_rd   = stim[i*FIELDS+5];
        exp_wr   = stim[i*FIELDS+6];
        rd0 = rd_reqs;
        rb0 = rd_beats;
        wr0 = wr_reqs;
        wb0 = wr_beats;
        r = '{write: op[0], addr: addr, wdata: wdata, wstrb: wstrb[3:0]};
        req       <= r;
        req_valid <= 1'b1;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (!req_ready);
        req_valid <= 1'b0;
        r.addr  = $random(seed);   // req is free after req_ready
        r.wdata = $random(seed);
        req     <= r;
        if (exp_rd == 0 && exp_wr == 0) check_equal(edges, 2, "hit req_ready timing");
        if (!op[0]) begin
            edges = 0;
            do begin
                @(posedge clk);
                edges++;
                if (edges == 1) check_equal(rsp_valid, 1, "rsp_valid one cycle after req_ready");
            end while (!(rsp_valid && rsp_ready));
            check_equal(rsp_data, exp_data, "read data");
        end
        @(posedge clk);
        check_equal(rsp_valid, 0, "extra response");
        check_equal(rd_reqs - rd0, exp_rd, "refill request count");
        check_equal(rd_beats - rb0, exp_rd * LINE_WORDS, "refill beat count");
        check_equal(wr_reqs - wr0, exp_wr, "write-back request count");
        check_equal(wr_beats - wb0, exp_wr * LINE_WORDS, "write-back beat count");
        if (exp_rd != 0) check_equal(rd_line, addr[31:OFFSET_BITS], "refill line address");
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        int count;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        count     = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = word_t'(a * 4 * 3 + 1);   // 3 * byte address + 1
        end
        for (int k = 0; k < MAX_ACC*FIELDS; k++) begin
            stim[k] = '1;   // end marker where the file stops
        end
        $readmemh("sim/dcache_input.txt", stim);
        while (count < MAX_ACC && stim[count*FIELDS] !== '1) count++;
        if (count == 0) begin
            $display("no accesses could be read from sim/dcache_input.txt");
            stop_with_failure();
        end
        n_acc = count;   // starts the watchdog
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (6) begin   // idle, nothing may move
            @(posedge clk);
            check_equal({req_ready, rsp_valid, rd_req_valid, wr_req_valid, wr_data_valid}, 0,
                        "outputs idle after reset");
        end
        for (int i = 0; i < count; i++) begin
            run_access(i);
        end
        $display("No errors");
        $finish;
    end

    initial begin : watchdog
        wait (n_acc > 0);
        #((n_acc * CYCLES_PER_ACC + 50) * CLK_PERIOD);
        $display("timeout: %0d accesses did not finish in time, stuck at access %0d",
                 n_acc, cur_access);
        stop_with_failure();
    end

endmodule

//--- src.f
verilog/cache_cfg_pkg.sv
verilog/cache_bus_pkg.sv
verilog/set_array.sv
verilog/line_data_array.sv
verilog/lru_victim_select.sv
verilog/writeback_buffer.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
sim/dcache_tb.sv

//--- verilog/cache_bus_pkg.sv
package cache_bus_pkg;

    import cache_cfg_pkg::*;

    // ----------------------------------------------------------------------
    // CPU side
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic        write;   // 1 write, 0 read
        logic [31:0] addr;    // word aligned
        word_t       wdata;
        logic [3:0]  wstrb;   // byte lanes of wdata
    } cpu_req_t;

    // ----------------------------------------------------------------------
    // memory side, refill data and write-back data alike
    // ----------------------------------------------------------------------
    typedef struct packed {
        word_t data;
        logic  last;   // eighth beat of the burst
    } mem_beat_t;

endpackage

//--- verilog/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // ----------------------------------------------------------------------
    // geometry
    // ----------------------------------------------------------------------
    localparam int NUM_WAYS    = 4;
    localparam int NUM_SETS    = 8;
    localparam int LINE_WORDS  = 8;   // words per line, one refill beat each
    localparam int WORD_BITS   = 32;
    localparam int OFFSET_BITS = 5;   // byte offset in a 32 byte line
    localparam int INDEX_BITS  = 3;
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int STAMP_BITS  = 16;

    // ----------------------------------------------------------------------
    // address fields and stored types
    // ----------------------------------------------------------------------
    typedef logic [WORD_BITS-1:0]            word_t;
    typedef logic [TAG_BITS-1:0]             tag_t;
    typedef logic [INDEX_BITS-1:0]           index_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]   word_sel_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]     way_t;
    typedef logic [LINE_WORDS*WORD_BITS-1:0] line_t;   // word 0 in the low bits
    typedef logic [STAMP_BITS-1:0]           stamp_t;

    // line address, no byte offset
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } line_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;   // written by the CPU since the refill
        tag_t tag;
    } line_meta_t;

endpackage

//--- verilog/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl import cache_cfg_pkg::*, cache_bus_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // CPU
    input  logic                req_valid,
    input  cpu_req_t            req,
    output logic                req_ready,
    output logic                rsp_valid,
    output word_t               rsp_data,
    input  logic                rsp_ready,
    // memory read
    output logic                rd_req_valid,
    output line_addr_t          rd_req_addr,
    input  logic                rd_req_ready,
    input  logic                rd_rsp_valid,
    input  mem_beat_t           rd_rsp,
    output logic                rd_rsp_ready,
    // memory write
    output logic                wr_req_valid,
    output line_addr_t          wr_req_addr,
    input  logic                wr_req_ready,
    output logic                wr_data_valid,
    output mem_beat_t           wr_data,
    input  logic                wr_data_ready,
    // arrays
    input  line_meta_t          metas [NUM_WAYS],
    input  line_t               lines [NUM_WAYS],
    input  way_t                victim,
    output logic [NUM_WAYS-1:0] meta_wen,
    output line_meta_t          meta_wdata,
    output logic [NUM_WAYS-1:0] stamp_wen,
    output logic                stamp_bump,
    output logic [NUM_WAYS-1:0] fill_en,
    output word_sel_t           fill_word,
    output logic [NUM_WAYS-1:0] hit_wen,
    // write-back buffer
    output logic                wb_load,
    output line_t               wb_line,
    input  logic                wb_done,
    input  mem_beat_t           wb_beat
);

    // one bit per state
    typedef struct packed {
        logic rd_resp;
        logic rd_hit;
        logic wr_hit;
        logic refill;
        logic miss_clean;
        logic writeback;
        logic miss_dirty;
        logic wait_req;
        logic init;
    } state_t;

    state_t     state, state_nxt;
    tag_t       req_tag;
    index_t     req_index;
    word_sel_t  req_word;
    logic       hit;
    way_t       hit_way;
    line_meta_t vic_meta;
    word_t      rsp_q;
    logic       hit_done;   // WR_HIT or RD_HIT, access retires

    // ----------------------------------------------------------------------
    // address split and tag compare
    // ----------------------------------------------------------------------
    assign req_tag   = req.addr[31 -: TAG_BITS];
    assign req_index = req.addr[OFFSET_BITS +: INDEX_BITS];
    assign req_word  = req.addr[2 +: $bits(word_sel_t)];
    assign vic_meta  = metas[victim];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (metas[w].valid && metas[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= '{init: 1'b1, default: 1'b0};
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = '0;
        if (state.init) state_nxt.wait_req = 1'b1;
        if (state.wait_req) begin
            if (!req_valid) begin
                state_nxt.wait_req = 1'b1;
            end else if (hit) begin
                state_nxt.wr_hit = req.write;
                state_nxt.rd_hit = !req.write;
            end else if (vic_meta.valid && vic_meta.dirty) begin
                state_nxt.miss_dirty = 1'b1;   // old line goes out first
            end else begin
                state_nxt.miss_clean = 1'b1;
            end
        end
        if (state.miss_dirty) begin
            state_nxt.writeback  = wr_req_ready;
            state_nxt.miss_dirty = !wr_req_ready;
        end
        if (state.writeback) begin
            state_nxt.miss_clean = wb_done;
            state_nxt.writeback  = !wb_done;
        end
        if (state.miss_clean) begin
            state_nxt.refill     = rd_req_ready;
            state_nxt.miss_clean = !rd_req_ready;
        end
        if (state.refill) begin
            if (rd_rsp_valid && rd_rsp.last) begin   // line now hits
                state_nxt.wr_hit = req.write;
                state_nxt.rd_hit = !req.write;
            end else begin
                state_nxt.refill = 1'b1;
            end
        end
        if (state.wr_hit) state_nxt.wait_req = 1'b1;
        if (state.rd_hit) state_nxt.rd_resp = 1'b1;
        if (state.rd_resp) begin
            state_nxt.wait_req = rsp_ready;
            state_nxt.rd_resp  = !rsp_ready;
        end
    end

    // ----------------------------------------------------------------------
    // CPU side
    // ----------------------------------------------------------------------
    assign hit_done  = state.wr_hit || state.rd_hit;
    assign req_ready = hit_done;   // CPU may drop req after this

    always_ff @(posedge clk) begin
        if (state.rd_hit) begin
            rsp_q <= lines[hit_way][req_word*WORD_BITS +: WORD_BITS];
        end
    end

    assign rsp_valid = state.rd_resp;
    assign rsp_data  = rsp_q;

    // ----------------------------------------------------------------------
    // memory side
    // ----------------------------------------------------------------------
    assign rd_req_valid = state.miss_clean;
    assign rd_req_addr  = '{tag: req_tag, index: req_index};
    assign rd_rsp_ready = state.refill;

    assign wr_req_valid  = state.miss_dirty;
    assign wr_req_addr   = '{tag: vic_meta.tag, index: req_index};   // evicted line
    assign wr_data_valid = state.writeback;
    assign wr_data       = wb_beat;

    assign wb_load = state.miss_dirty && wr_req_ready;   // load on handshake only
    assign wb_line = lines[victim];

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_word <= '0;
        end else if (state.refill && rd_rsp_valid) begin
            fill_word <= fill_word + 1'b1;   // wraps to 0 after beat 8
        end
    end

    // ----------------------------------------------------------------------
    // array writes
    // ----------------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            fill_en[w]   = state.refill && rd_rsp_valid && victim == way_t'(w);
            hit_wen[w]   = state.wr_hit && hit && hit_way == way_t'(w);
            stamp_wen[w] = hit_done && hit && hit_way == way_t'(w);
            meta_wen[w]  = hit_wen[w] || (fill_en[w] && rd_rsp.last);
        end
    end

    assign meta_wdata = '{valid: 1'b1, dirty: state.wr_hit, tag: req_tag};
    assign stamp_bump = hit_done;

    a_state_onehot : assert property (@(posedge clk) disable iff (rst)
        $onehot(state));

    // buffer finishes on an accepted beat of this write-back
    a_wb_done : assert property (@(posedge clk) disable iff (rst)
        wb_done |-> state.writeback && wr_data_ready);

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/10ps

module dcache_top import cache_cfg_pkg::*, cache_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // CPU request and response
    input  logic       req_valid,
    input  cpu_req_t   req,
    output logic       req_ready,
    output logic       rsp_valid,
    output word_t      rsp_data,
    input  logic       rsp_ready,
    // refill
    output logic       rd_req_valid,
    output line_addr_t rd_req_addr,
    input  logic       rd_req_ready,
    input  logic       rd_rsp_valid,
    input  mem_beat_t  rd_rsp,
    output logic       rd_rsp_ready,
    // write-back
    output logic       wr_req_valid,
    output line_addr_t wr_req_addr,
    input  logic       wr_req_ready,
    output logic       wr_data_valid,
    output mem_beat_t  wr_data,
    input  logic       wr_data_ready
);

    line_meta_t          metas [NUM_WAYS];
    stamp_t              stamps [NUM_WAYS];
    line_t               lines [NUM_WAYS];
    logic [NUM_WAYS-1:0] meta_wen, stamp_wen, fill_en, hit_wen;
    line_meta_t          meta_wdata;
    word_sel_t           fill_word;
    stamp_t              stamp_now;
    logic                stamp_bump;
    way_t                victim;
    logic                wb_load, wb_done;
    line_t               wb_line;
    mem_beat_t           wb_beat;
    index_t              req_index;

    assign req_index = req.addr[OFFSET_BITS +: INDEX_BITS];

    // ----------------------------------------------------------------------
    // storage per way
    // ----------------------------------------------------------------------
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        set_array #(.entry_t(line_meta_t)) u_meta (
            .clk, .rst, .wen(meta_wen[w]), .waddr(req_index), .wdata(meta_wdata),
            .raddr(req_index), .rdata(metas[w])
        );

        set_array #(.entry_t(stamp_t)) u_stamp (
            .clk, .rst, .wen(stamp_wen[w]), .waddr(req_index), .wdata(stamp_now),
            .raddr(req_index), .rdata(stamps[w])
        );

        line_data_array u_data (
            .clk, .fill_en(fill_en[w]), .fill_word, .fill_data(rd_rsp.data),
            .hit_wen(hit_wen[w]), .hit_word(req.addr[2 +: $bits(word_sel_t)]),
            .wdata(req.wdata), .wstrb(req.wstrb), .index(req_index), .rdata(lines[w])
        );
    end

    // ----------------------------------------------------------------------
    // policy, write-back and control
    // ----------------------------------------------------------------------
    lru_victim_select u_lru (
        .clk, .rst, .stamp_bump, .stamps, .stamp_now, .victim
    );

    writeback_buffer u_wb (
        .clk, .rst, .load(wb_load), .line_in(wb_line), .beat_ready(wr_data_ready),
        .beat(wb_beat), .done(wb_done)
    );

    cache_ctrl u_ctrl (
        .clk, .rst,
        .req_valid, .req, .req_ready, .rsp_valid, .rsp_data, .rsp_ready,
        .rd_req_valid, .rd_req_addr, .rd_req_ready, .rd_rsp_valid, .rd_rsp, .rd_rsp_ready,
        .wr_req_valid, .wr_req_addr, .wr_req_ready, .wr_data_valid, .wr_data,
        .wr_data_ready,
        .metas, .lines, .victim, .meta_wen, .meta_wdata, .stamp_wen, .stamp_bump,
        .fill_en, .fill_word, .hit_wen,
        .wb_load, .wb_line, .wb_done, .wb_beat
    );

endmodule

//--- verilog/line_data_array.sv
`timescale 1ns/10ps

module line_data_array import cache_cfg_pkg::*; (
    input  logic       clk,
    // refill port, whole words
    input  logic       fill_en,
    input  word_sel_t  fill_word,
    input  word_t      fill_data,
    // write hit port, byte lanes
    input  logic       hit_wen,
    input  word_sel_t  hit_word,
    input  word_t      wdata,
    input  logic [3:0] wstrb,
    input  index_t     index,
    output line_t      rdata
);

    line_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            mem[index][fill_word*WORD_BITS +: WORD_BITS] <= fill_data;
        end else if (hit_wen) begin
            for (int b = 0; b < WORD_BITS/8; b++) begin
                if (wstrb[b]) begin   // untouched lanes keep old bytes
                    mem[index][hit_word*WORD_BITS + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[index];   // whole line of the set

    // refill and write hit live in different FSM states
    a_one_writer : assert property (@(posedge clk)
        !(fill_en && hit_wen));

endmodule

//--- verilog/lru_victim_select.sv
`timescale 1ns/10ps

module lru_victim_select import cache_cfg_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stamp_bump,            // one access finished
    input  stamp_t stamps [NUM_WAYS],     // stamps of the indexed set
    output stamp_t stamp_now,
    output way_t   victim
);

    stamp_t best_stamp;

    // ----------------------------------------------------------------------
    // access counter, saturating
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            stamp_now <= stamp_t'(1);   // 0 stays reserved for unused ways
        end else if (stamp_bump && stamp_now != '1) begin
            stamp_now <= stamp_now + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // smallest stamp wins, strict compare keeps the lowest way on ties
    // ----------------------------------------------------------------------
    always_comb begin
        victim     = '0;
        best_stamp = stamps[0];
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (stamps[w] < best_stamp) begin
                victim     = way_t'(w);
                best_stamp = stamps[w];
            end
        end
    end

endmodule

//--- verilog/set_array.sv
`timescale 1ns/10ps

// one entry per set, for one way
module set_array import cache_cfg_pkg::*; #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   wen,
    input  index_t waddr,
    input  entry_t wdata,
    input  index_t raddr,
    output entry_t rdata
);

    entry_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                mem[i] <= '0;   // invalid, clean, never used
            end
        end else if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];   // async read, ctrl decides in the same cycle

    a_waddr_known : assert property (@(posedge clk) disable iff (rst)
        wen |-> !$isunknown(waddr));

endmodule

//--- verilog/writeback_buffer.sv
`timescale 1ns/10ps

module writeback_buffer import cache_cfg_pkg::*, cache_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      load,         // victim line captured this cycle
    input  line_t     line_in,
    input  logic      beat_ready,
    output mem_beat_t beat,
    output logic      done          // last beat accepted
);

    line_t      shift_q;   // word 0 sits in the low bits
    logic [3:0] cnt_q;     // beats already accepted, 8 when idle
    logic       active;
    logic       advance;

    assign active  = (cnt_q < 4'(LINE_WORDS));
    assign advance = active && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= 4'(LINE_WORDS);   // idle until loaded
        end else if (load) begin
            cnt_q <= '0;
        end else if (advance) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= line_in;
        end else if (advance) begin
            shift_q <= shift_q >> WORD_BITS;   // next word drops into place
        end
    end

    assign beat.data = shift_q[WORD_BITS-1:0];
    assign beat.last = (cnt_q == 4'(LINE_WORDS - 1));
    assign done      = advance && beat.last;

    // new victim only once all 8 beats of the previous burst went out
    a_load_idle : assert property (@(posedge clk) disable iff (rst)
        load |-> cnt_q == 4'(LINE_WORDS));

endmodule
